// ==== rtl/isa_pkg.sv ====
// Instruction set of the stack_core processor
// An instruction word is the opcode on top of the operand field
// Shared by the fetch stage, the decoder and the testbench model

package isa_pkg;

	// Opcode field width, fixed by the instruction set
	localparam int NBOPCO = 5;

	// ----------------------------
	// Opcodes
	// ----------------------------
	typedef enum logic [NBOPCO-1:0] {
		NOP  = 5'd0,
		// Memory and stack transfers
		LOD  = 5'd1,
		STO  = 5'd2,
		PSH  = 5'd3,
		POP  = 5'd4,
		// Indexed IO
		INN  = 5'd5,
		OUT  = 5'd6,
		// ALU, memory or stack operand
		ADD  = 5'd7,
		SADD = 5'd8,
		AND  = 5'd9,
		SAND = 5'd10,
		ORR  = 5'd11,
		XOR  = 5'd12,
		LES  = 5'd13,
		SLES = 5'd14,
		EQU  = 5'd15,
		// One-bit shifts of acc
		SHL  = 5'd16,
		SHR  = 5'd17,
		// Flow control, operand is the target address
		JMP  = 5'd18,
		JIZ  = 5'd19,
		CAL  = 5'd20,
		RET  = 5'd21
	} opcode_t;

endpackage

// ==== rtl/alu_pkg.sv ====
// ALU control types of the stack_core processor
// Driven by the decoder, consumed by the ALU

package alu_pkg;

	// ----------------------------
	// Operation select
	// ----------------------------
	typedef enum logic [3:0] {
		PASS = 4'd0,  // result is the second operand
		HOLD = 4'd1,  // acc keeps its value
		ADD  = 4'd2,
		AND  = 4'd3,
		ORR  = 4'd4,
		XOR  = 4'd5,
		LES  = 4'd6,  // signed compare
		EQU  = 4'd7,
		SHL  = 4'd8,
		SHR  = 4'd9   // arithmetic
	} alu_op_t;

	// ----------------------------
	// Second operand source
	// ----------------------------
	typedef enum logic [1:0] {
		SRC_MEM = 2'd0,
		SRC_IO  = 2'd1,
		SRC_STK = 2'd2
	} src_t;

endpackage

// ==== rtl/lifo.sv ====
// Generic last-in-first-out stack with a combinational top
// Used for the return-address stack and for the data stack

module lifo #(
	parameter int NBITS = 16,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [NBITS-1:0] din,
	output logic [NBITS-1:0] top,
	output logic             empty,
	output logic             full
);

	// Pointer counts 0 to DEPTH, index covers the array
	localparam int PW = $clog2(DEPTH + 1);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [NBITS-1:0] mem [DEPTH];
	logic [PW-1:0]    ptr;
	logic [AW-1:0]    wr_idx;
	logic [AW-1:0]    top_idx;

	assign empty   = (ptr == '0);
	assign full    = (ptr == PW'(DEPTH));
	assign wr_idx  = AW'(ptr);
	assign top_idx = AW'(ptr - PW'(1));

	// Top is the last written entry
	assign top = empty ? '0 : mem[top_idx];

	// Pointer points at the next free slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push && !full) begin
			ptr <= ptr + PW'(1);
		end else if (pop && !empty) begin
			ptr <= ptr - PW'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (push && !full) begin
			mem[wr_idx] <= din;
		end
	end

	no_overflow:  assert property (@(posedge clk) disable iff (rst) !(push && full));
	no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

// ==== rtl/instr_fetch.sv ====
// Fetch stage: program counter, branch resolution and return-address stack
// Splits the instruction word and picks the next address every clock

module instr_fetch #(
	parameter int NBOPER = 8,
	parameter int MINSTW = 8,
	parameter int SDEPTH = 4
) (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [isa_pkg::NBOPCO+NBOPER-1:0] instr,
	input  logic                             call,
	input  logic                             ret,
	input  logic                             acc_zero,
	output logic [MINSTW-1:0]                instr_addr,
	output isa_pkg::opcode_t                 opcode,
	output logic [NBOPER-1:0]                operand
);

	logic [MINSTW-1:0] pc;
	logic [MINSTW-1:0] pc_inc;
	logic [MINSTW-1:0] pc_next;
	logic [MINSTW-1:0] target;
	logic [MINSTW-1:0] ret_addr;
	logic              take;

	// ----------------------------
	// Instruction fields
	// ----------------------------
	assign opcode  = isa_pkg::opcode_t'(instr[isa_pkg::NBOPCO+NBOPER-1:NBOPER]);
	assign operand = instr[NBOPER-1:0];

	// Branch target is the low bits of the operand
	assign target = MINSTW'(operand);
	assign pc_inc = pc + MINSTW'(1);

	// JMP always, JIZ on zero acc, CAL via decoder
	assign take = (opcode == isa_pkg::JMP) ||
	              ((opcode == isa_pkg::JIZ) && acc_zero) ||
	              call;

	always_comb begin
		if (ret) begin
			pc_next = ret_addr;
		end else if (take) begin
			pc_next = target;
		end else begin
			pc_next = pc_inc;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	assign instr_addr = pc;

	// Return-address stack, holds the address after each CAL
	lifo #(
		.NBITS(MINSTW),
		.DEPTH(SDEPTH)
	) ras (
		.clk  (clk),
		.rst  (rst),
		.push (call),
		.pop  (ret),
		.din  (pc_inc),
		.top  (ret_addr),
		.empty(),
		.full ()
	);

endmodule

// ==== rtl/instr_dec.sv ====
// Control unit of the stack_core processor
// Maps the current opcode to ALU, stack, branch and port controls
// Purely combinational, strobes held low during reset

module instr_dec (
	input  logic              rst,
	input  isa_pkg::opcode_t  opcode,
	output alu_pkg::alu_op_t  alu_op,
	output alu_pkg::src_t     src,
	output logic              push,
	output logic              pop,
	output logic              call,
	output logic              ret,
	output logic              mem_wr,
	output logic              req_in,
	output logic              out_en
);

	// Ungated strobes
	logic push_d;
	logic pop_d;
	logic call_d;
	logic ret_d;
	logic wr_d;
	logic req_d;
	logic out_d;

	// ----------------------------
	// Decode table
	// ----------------------------
	always_comb begin
		alu_op = alu_pkg::HOLD;
		src    = alu_pkg::SRC_MEM;
		push_d = 1'b0;
		pop_d  = 1'b0;
		call_d = 1'b0;
		ret_d  = 1'b0;
		wr_d   = 1'b0;
		req_d  = 1'b0;
		out_d  = 1'b0;
		case (opcode)
			isa_pkg::LOD: alu_op = alu_pkg::PASS;
			isa_pkg::STO: wr_d = 1'b1;
			isa_pkg::PSH: push_d = 1'b1;
			isa_pkg::POP: begin
				alu_op = alu_pkg::PASS;
				src    = alu_pkg::SRC_STK;
				pop_d  = 1'b1;
			end
			isa_pkg::INN: begin
				alu_op = alu_pkg::PASS;
				src    = alu_pkg::SRC_IO;
				req_d  = 1'b1;
			end
			isa_pkg::OUT: out_d = 1'b1;
			// Memory operand forms
			isa_pkg::ADD: alu_op = alu_pkg::ADD;
			isa_pkg::AND: alu_op = alu_pkg::AND;
			isa_pkg::ORR: alu_op = alu_pkg::ORR;
			isa_pkg::XOR: alu_op = alu_pkg::XOR;
			isa_pkg::LES: alu_op = alu_pkg::LES;
			isa_pkg::EQU: alu_op = alu_pkg::EQU;
			// Stack operand forms consume the top
			isa_pkg::SADD: begin
				alu_op = alu_pkg::ADD;
				src    = alu_pkg::SRC_STK;
				pop_d  = 1'b1;
			end
			isa_pkg::SAND: begin
				alu_op = alu_pkg::AND;
				src    = alu_pkg::SRC_STK;
				pop_d  = 1'b1;
			end
			isa_pkg::SLES: begin
				alu_op = alu_pkg::LES;
				src    = alu_pkg::SRC_STK;
				pop_d  = 1'b1;
			end
			isa_pkg::SHL: alu_op = alu_pkg::SHL;
			isa_pkg::SHR: alu_op = alu_pkg::SHR;
			// JMP and JIZ are resolved in fetch
			isa_pkg::CAL: call_d = 1'b1;
			isa_pkg::RET: ret_d = 1'b1;
			default: alu_op = alu_pkg::HOLD;
		endcase
	end

	// Reset gating
	assign push   = push_d & ~rst;
	assign pop    = pop_d  & ~rst;
	assign call   = call_d & ~rst;
	assign ret    = ret_d  & ~rst;
	assign mem_wr = wr_d   & ~rst;
	assign req_in = req_d  & ~rst;
	assign out_en = out_d  & ~rst;

	no_push_pop: assert final (!(push && pop));

endmodule

// ==== rtl/alu.sv ====
// Integer ALU and accumulator of the stack_core processor
// Second operand from memory, IO or data-stack top, result into acc

module alu #(
	parameter int NUBITS = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  alu_pkg::alu_op_t  alu_op,
	input  alu_pkg::src_t     src,
	input  logic [NUBITS-1:0] mem_data,
	input  logic [NUBITS-1:0] io_data,
	input  logic [NUBITS-1:0] stack_top,
	output logic [NUBITS-1:0] acc,
	output logic              acc_zero
);

	logic [NUBITS-1:0] opb;
	logic [NUBITS-1:0] result;

	// ----------------------------
	// Operand select
	// ----------------------------
	always_comb begin
		case (src)
			alu_pkg::SRC_IO:  opb = io_data;
			alu_pkg::SRC_STK: opb = stack_top;
			default:          opb = mem_data;
		endcase
	end

	// ----------------------------
	// Operations against acc
	// ----------------------------
	always_comb begin
		case (alu_op)
			alu_pkg::PASS: result = opb;
			alu_pkg::ADD:  result = acc + opb;
			alu_pkg::AND:  result = acc & opb;
			alu_pkg::ORR:  result = acc | opb;
			alu_pkg::XOR:  result = acc ^ opb;
			// Compares give 0 or 1
			alu_pkg::LES:  result = NUBITS'($signed(acc) < $signed(opb));
			alu_pkg::EQU:  result = NUBITS'(acc == opb);
			alu_pkg::SHL:  result = acc << 1;
			// Sign bit kept
			alu_pkg::SHR:  result = $unsigned($signed(acc) >>> 1);
			default:       result = acc;
		endcase
	end

	// Accumulator
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= result;
		end
	end

	// Zero flag of the current acc, used by JIZ
	assign acc_zero = (acc == '0);

endmodule

// ==== rtl/stack_core.sv ====
// Top level of the stack_core processor
// One instruction per clock, memories and IO answer within the cycle
// Parameters set here are passed down to every block

module stack_core #(
	parameter int NUBITS = 16,
	parameter int NBOPER = 8,
	parameter int MINSTW = 8,
	parameter int MDATAW = 6,
	parameter int SDEPTH = 4,
	parameter int DDEPTH = 8,
	parameter int NUIOIN = 4,
	parameter int NUIOOU = 4
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [isa_pkg::NBOPCO+NBOPER-1:0] instr,
	output logic [MINSTW-1:0]                 instr_addr,
	output logic                              mem_wr,
	output logic [MDATAW-1:0]                 mem_addr,
	input  logic [NUBITS-1:0]                 mem_data_in,
	output logic [NUBITS-1:0]                 data_out,
	input  logic [NUBITS-1:0]                 io_in,
	output logic [$clog2(NUIOIN)-1:0]         addr_in,
	output logic [$clog2(NUIOOU)-1:0]         addr_out,
	output logic                              req_in,
	output logic                              out_en
);

	isa_pkg::opcode_t  opcode;
	logic [NBOPER-1:0] operand;
	alu_pkg::alu_op_t  alu_op;
	alu_pkg::src_t     src;
	logic              push;
	logic              pop;
	logic              call;
	logic              ret;
	logic              acc_zero;
	logic [NUBITS-1:0] stack_top;

	// ----------------------------
	// Fetch and decode
	// ----------------------------
	instr_fetch #(
		.NBOPER(NBOPER),
		.MINSTW(MINSTW),
		.SDEPTH(SDEPTH)
	) u_fetch (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.call      (call),
		.ret       (ret),
		.acc_zero  (acc_zero),
		.instr_addr(instr_addr),
		.opcode    (opcode),
		.operand   (operand)
	);

	instr_dec u_dec (
		.rst   (rst),
		.opcode(opcode),
		.alu_op(alu_op),
		.src   (src),
		.push  (push),
		.pop   (pop),
		.call  (call),
		.ret   (ret),
		.mem_wr(mem_wr),
		.req_in(req_in),
		.out_en(out_en)
	);

	// ----------------------------
	// Datapath
	// ----------------------------
	// PSH stores acc, stack ops read the top
	lifo #(
		.NBITS(NUBITS),
		.DEPTH(DDEPTH)
	) u_dstack (
		.clk  (clk),
		.rst  (rst),
		.push (push),
		.pop  (pop),
		.din  (data_out),
		.top  (stack_top),
		.empty(),
		.full ()
	);

	// acc doubles as the store and output data
	alu #(
		.NUBITS(NUBITS)
	) u_alu (
		.clk      (clk),
		.rst      (rst),
		.alu_op   (alu_op),
		.src      (src),
		.mem_data (mem_data_in),
		.io_data  (io_in),
		.stack_top(stack_top),
		.acc      (data_out),
		.acc_zero (acc_zero)
	);

	// Port addresses are low operand bits
	assign mem_addr = operand[MDATAW-1:0];
	assign addr_in  = operand[$clog2(NUIOIN)-1:0];
	assign addr_out = operand[$clog2(NUIOOU)-1:0];

endmodule

// ==== verif/clk_gen.sv ====
// Clock and reset source for the stack_core testbench
// Free-running clock, reset released shortly after a fixed number of edges

module clk_gen #(
	parameter int PERIOD     = 8,
	parameter int RST_CYCLES = 5
) (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Release 1 ns after the last reset edge, like other inputs
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// ==== verif/stack_core_tb.sv ====
// Testbench for stack_core
// Builds a random program with a fixed seed, runs it on the DUT and on an
// instruction-set model, and compares pc, stores, IO strobes and data each cycle

module stack_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUBITS = 16;
	localparam int NBOPER = 8;
	localparam int MINSTW = 8;
	localparam int MDATAW = 6;
	localparam int SDEPTH = 4;
	localparam int DDEPTH = 8;
	localparam int NUIOIN = 4;
	localparam int NUIOOU = 4;
	localparam int IW     = isa_pkg::NBOPCO + NBOPER;
	localparam int DW     = $clog2(DDEPTH);
	localparam int SW     = $clog2(SDEPTH);

	// ----------------------------
	// Program layout
	// ----------------------------
	localparam int MAIN_LEN   = 120;
	localparam int NSUB       = 3;
	localparam int SUB_LEN    = 8;
	localparam int PROG_LEN   = MAIN_LEN + NSUB * SUB_LEN;
	localparam int MAX_CYCLES = PROG_LEN * 4 + 50;

	logic                      clk;
	logic                      rst;
	logic [IW-1:0]             instr;
	logic [MINSTW-1:0]         instr_addr;
	logic                      mem_wr;
	logic [MDATAW-1:0]         mem_addr;
	logic [NUBITS-1:0]         mem_data_in;
	logic [NUBITS-1:0]         data_out;
	logic [NUBITS-1:0]         io_in;
	logic [$clog2(NUIOIN)-1:0] addr_in;
	logic [$clog2(NUIOOU)-1:0] addr_out;
	logic                      req_in;
	logic                      out_en;

	// Instruction memory, data memory, IO input values
	logic [IW-1:0]     imem    [2**MINSTW];
	logic [NUBITS-1:0] dmem    [2**MDATAW];
	logic [NUBITS-1:0] io_vals [NUIOIN];

	// Model state
	logic [NUBITS-1:0] m_mem  [2**MDATAW];
	logic [NUBITS-1:0] m_dstk [DDEPTH];
	logic [MINSTW-1:0] m_rstk [SDEPTH];
	logic [NUBITS-1:0] m_acc;
	logic [MINSTW-1:0] m_pc;
	int                m_dsp;
	int                m_rsp;

	integer seed = 42;
	int     errors;
	int     timeouts;

	clk_gen #(.PERIOD(8), .RST_CYCLES(5)) u_clk (.clk(clk), .rst(rst));

	stack_core #(
		.NUBITS(NUBITS), .NBOPER(NBOPER), .MINSTW(MINSTW), .MDATAW(MDATAW),
		.SDEPTH(SDEPTH), .DDEPTH(DDEPTH), .NUIOIN(NUIOIN), .NUIOOU(NUIOOU)
	) dut (
		.clk(clk), .rst(rst), .instr(instr), .instr_addr(instr_addr),
		.mem_wr(mem_wr), .mem_addr(mem_addr), .mem_data_in(mem_data_in),
		.data_out(data_out), .io_in(io_in), .addr_in(addr_in), .addr_out(addr_out),
		.req_in(req_in), .out_en(out_en)
	);

	// Memories answer within the cycle
	assign instr       = imem[instr_addr];
	assign mem_data_in = dmem[mem_addr];
	assign io_in       = req_in ? io_vals[addr_in] : '0;

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [IW-1:0] make_instr(isa_pkg::opcode_t op, int opnd);
		return {op, NBOPER'(opnd)};
	endfunction

	// No stack or flow effect, safe inside a jump window or a subroutine
	function automatic logic [IW-1:0] neutral_instr();
		isa_pkg::opcode_t ops [15] = '{isa_pkg::LOD, isa_pkg::STO, isa_pkg::STO,
			isa_pkg::INN, isa_pkg::OUT, isa_pkg::OUT, isa_pkg::ADD, isa_pkg::AND,
			isa_pkg::ORR, isa_pkg::XOR, isa_pkg::LES, isa_pkg::EQU, isa_pkg::SHL,
			isa_pkg::SHR, isa_pkg::NOP};
		return make_instr(ops[4'(rand_below(15))], rand_below(256));
	endfunction

	// ----------------------------
	// Random program
	// ----------------------------
	task automatic gen_program();
		int depth;
		int skip;
		int k;
		int r;
		logic [IW-1:0] w;
		depth = 0;
		skip  = 0;
		foreach (imem[i]) imem[i] = '0;
		for (int pc = 0; pc < MAIN_LEN - 1; pc++) begin
			r = rand_below(10);
			if (skip > 0) begin
				w = neutral_instr();
				skip--;
			end else if (r == 0 && pc + 6 < MAIN_LEN - 1) begin
				// Forward only, skipped window keeps the stack depth
				k    = 1 + rand_below(4);
				w    = make_instr(rand_below(2) == 0 ? isa_pkg::JMP : isa_pkg::JIZ, pc + 1 + k);
				skip = k;
			end else if (r == 1) begin
				w = make_instr(isa_pkg::CAL, MAIN_LEN + rand_below(NSUB) * SUB_LEN);
			end else if (r <= 4) begin
				r = rand_below(5);
				if (depth == 0 || (r == 0 && depth < DDEPTH)) begin
					w = make_instr(isa_pkg::PSH, rand_below(256));
					depth++;
				end else begin
					case (r)
						1:       w = make_instr(isa_pkg::POP, rand_below(256));
						2:       w = make_instr(isa_pkg::SADD, rand_below(256));
						3:       w = make_instr(isa_pkg::SAND, rand_below(256));
						default: w = make_instr(isa_pkg::SLES, rand_below(256));
					endcase
					depth--;
				end
			end else begin
				w = neutral_instr();
			end
			imem[MINSTW'(pc)] = w;
		end
		// Final self-jump
		imem[MINSTW'(MAIN_LEN - 1)] = make_instr(isa_pkg::JMP, MAIN_LEN - 1);
		for (int s = 0; s < NSUB; s++) begin
			for (int j = 0; j < SUB_LEN - 1; j++)
				imem[MINSTW'(MAIN_LEN + s * SUB_LEN + j)] = neutral_instr();
			imem[MINSTW'(MAIN_LEN + (s + 1) * SUB_LEN - 1)] = make_instr(isa_pkg::RET, 0);
		end
	endtask

	task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
		$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		errors++;
	endtask

	// ----------------------------
	// Checks, then one model step
	// ----------------------------
	task automatic check_and_step();
		logic [IW-1:0]     word;
		isa_pkg::opcode_t  op;
		logic [NBOPER-1:0] opnd;
		logic [NUBITS-1:0] mval;
		logic [MINSTW-1:0] next_pc;
		word    = imem[m_pc];
		op      = isa_pkg::opcode_t'(word[IW-1:NBOPER]);
		opnd    = word[NBOPER-1:0];
		mval    = m_mem[opnd[MDATAW-1:0]];
		next_pc = m_pc + MINSTW'(1);
		if (instr_addr !== m_pc)
			report_mismatch("instr_addr", 32'(instr_addr), 32'(m_pc));
		if (mem_wr !== (op == isa_pkg::STO))
			report_mismatch("mem_wr", 32'(mem_wr), 32'(op == isa_pkg::STO));
		if (req_in !== (op == isa_pkg::INN))
			report_mismatch("req_in", 32'(req_in), 32'(op == isa_pkg::INN));
		if (out_en !== (op == isa_pkg::OUT))
			report_mismatch("out_en", 32'(out_en), 32'(op == isa_pkg::OUT));
		if (op == isa_pkg::STO && mem_addr !== opnd[MDATAW-1:0])
			report_mismatch("mem_addr", 32'(mem_addr), 32'(opnd[MDATAW-1:0]));
		if (op == isa_pkg::INN && addr_in !== opnd[1:0])
			report_mismatch("addr_in", 32'(addr_in), 32'(opnd[1:0]));
		if (op == isa_pkg::OUT && addr_out !== opnd[1:0])
			report_mismatch("addr_out", 32'(addr_out), 32'(opnd[1:0]));
		// Stored or output value is the model acc
		if ((op == isa_pkg::STO || op == isa_pkg::OUT) && data_out !== m_acc)
			report_mismatch("data_out", 32'(data_out), 32'(m_acc));
		// Pops read the top first
		if (op == isa_pkg::POP || op == isa_pkg::SADD || op == isa_pkg::SAND ||
		    op == isa_pkg::SLES) begin
			m_dsp--;
			mval = m_dstk[DW'(m_dsp)];
		end
		case (op)
			isa_pkg::LOD, isa_pkg::POP: m_acc = mval;
			isa_pkg::STO: m_mem[opnd[MDATAW-1:0]] = m_acc;
			isa_pkg::PSH: begin
				m_dstk[DW'(m_dsp)] = m_acc;
				m_dsp++;
			end
			isa_pkg::INN: m_acc = io_vals[opnd[1:0]];
			isa_pkg::ADD, isa_pkg::SADD: m_acc = m_acc + mval;
			isa_pkg::AND, isa_pkg::SAND: m_acc = m_acc & mval;
			isa_pkg::ORR: m_acc = m_acc | mval;
			isa_pkg::XOR: m_acc = m_acc ^ mval;
			isa_pkg::LES, isa_pkg::SLES: m_acc = ($signed(m_acc) < $signed(mval)) ? 16'd1 : 16'd0;
			isa_pkg::EQU: m_acc = (m_acc == mval) ? 16'd1 : 16'd0;
			isa_pkg::SHL: m_acc = {m_acc[NUBITS-2:0], 1'b0};
			isa_pkg::SHR: m_acc = {m_acc[NUBITS-1], m_acc[NUBITS-1:1]};
			isa_pkg::JMP: next_pc = MINSTW'(opnd);
			isa_pkg::JIZ: if (m_acc == '0) next_pc = MINSTW'(opnd);
			isa_pkg::CAL: begin
				m_rstk[SW'(m_rsp)] = next_pc;
				m_rsp++;
				next_pc = MINSTW'(opnd);
			end
			isa_pkg::RET: begin
				m_rsp--;
				next_pc = m_rstk[SW'(m_rsp)];
			end
			default: m_acc = m_acc;
		endcase
		m_pc = next_pc;
	endtask

	initial begin
		int                cycles;
		logic              done;
		logic [MINSTW-1:0] prev_addr;
		errors   = 0;
		timeouts = 0;
		foreach (dmem[i]) begin
			dmem[i]  = NUBITS'($random(seed));
			m_mem[i] = dmem[i];
		end
		foreach (io_vals[i]) io_vals[i] = NUBITS'($random(seed));
		gen_program();
		m_pc  = '0;
		m_acc = '0;
		m_dsp = 0;
		m_rsp = 0;

		// Reset state
		repeat (2) @(posedge clk);
		#1;
		if (instr_addr !== '0)
			report_mismatch("instr_addr in reset", 32'(instr_addr), 32'd0);
		if ({mem_wr, req_in, out_en} !== 3'b000)
			report_mismatch("strobes in reset", 32'({mem_wr, req_in, out_en}), 32'd0);

		wait (rst == 1'b0);
		#1;
		cycles    = 0;
		done      = 1'b0;
		prev_addr = '1;
		while (!done && cycles < MAX_CYCLES) begin
			// Final self-jump holds instr_addr
			done      = (instr_addr === prev_addr);
			prev_addr = instr_addr;
			check_and_step();
			if (mem_wr)
				dmem[mem_addr] = data_out;
			@(posedge clk);
			#1;
			cycles++;
		end

		if (!done) begin
			$display("Timeout: program did not reach its final jump within %0d cycles",
				MAX_CYCLES);
			timeouts++;
		end
		$display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== stack_core.f ====
rtl/isa_pkg.sv
rtl/alu_pkg.sv
rtl/lifo.sv
rtl/instr_fetch.sv
rtl/instr_dec.sv
rtl/alu.sv
rtl/stack_core.sv
verif/clk_gen.sv
verif/stack_core_tb.sv

// ==== Makefile ====
# Verilator build and run, lint and clean for stack_core

LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f stack_core.f \
		--top-module stack_core_tb -Mdir obj_dir

run: build
	./obj_dir/Vstack_core_tb | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert -f stack_core.f --top-module stack_core

clean:
	rm -rf obj_dir $(LOG)
